// File: Makefile
# Verilator build and run for the ping-pong FIFO stream testbench

TOP := tb_ppfifo_stream

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f compile.f \
		--Mdir obj_dir -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// File: compile.f
verilog/ppfifo_pkg.sv
verilog/ppfifo.sv
verilog/ppfifo_writer.sv
verilog/adapter_ppfifo_2_axi_stream.sv
verilog/ppfifo_stream_top.sv
verif/tb_ppfifo_stream.sv

// File: verif/tb_ppfifo_stream.sv
// testbench for the ping-pong FIFO stream path
//   stimulus table walked by a driver loop
//   galois LFSR back-pressure on the output
//   scoreboard queue checked by a transfer monitor
//   error counts and verdict at the end
`timescale 1ns/10ps
`default_nettype none

module tb_ppfifo_stream;

  import ppfifo_pkg::*;

  // output ready behavior per row
  typedef enum logic [1:0] {
    MODE_READY,
    MODE_LFSR,
    MODE_STALL
  } ready_mode_t;

  // one table row, pkts is the packet count it must produce
  typedef struct packed {
    int          words;
    logic        flush;
    ready_mode_t mode;
    int          pkts;
  } row_t;

  localparam int NUM_ROWS     = 9;
  localparam int WAIT_LIMIT   = 2000;
  localparam int STALL_CYCLES = 30;

  logic        clk;
  logic        rst;
  logic        i_in_stb;
  data_t       i_in_data;
  logic        i_flush;
  logic        o_in_rdy;
  logic        i_axis_ready;
  logic        o_axis_valid;
  axis_beat_t  o_axis_beat;

  row_t        rows [0:NUM_ROWS-1];
  axis_beat_t  exp_q [$];
  ready_mode_t cur_mode = MODE_READY;
  logic        stall_hold = 1'b0;
  logic [31:0] lfsr_state;
  int          bank_words;

  // beat seen stalled last edge
  logic        hold_pending = 1'b0;
  axis_beat_t  held_beat;

  int data_errs = 0;
  int last_errs = 0;
  int hold_errs = 0;
  int ctrl_errs = 0;
  int timeout_errs = 0;
  int pkt_cnt = 0;

  ppfifo_stream_top #(
    .DEPTH_LOG2 (4)
  ) ppfifo_stream_top_inst (
    .clk          (clk),
    .rst          (rst),
    .i_in_stb     (i_in_stb),
    .i_in_data    (i_in_data),
    .i_flush      (i_flush),
    .o_in_rdy     (o_in_rdy),
    .i_axis_ready (i_axis_ready),
    .o_axis_valid (o_axis_valid),
    .o_axis_beat  (o_axis_beat)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1, shift right form
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  task automatic set_row(input int idx, input int words, input logic flush,
                         input ready_mode_t mode, input int pkts);
    rows[idx].words = words;
    rows[idx].flush = flush;
    rows[idx].mode  = mode;
    rows[idx].pkts  = pkts;
  endtask

  task automatic load_table();
    // three full banks back to back
    set_row(0, 48, 1'b0, MODE_READY, 3);
    // short packet closed by flush
    set_row(1, 5, 1'b1, MODE_READY, 1);
    // flush with nothing stored, no packet
    set_row(2, 0, 1'b1, MODE_READY, 0);
    set_row(3, 3, 1'b1, MODE_READY, 1);
    // random ready, 16 + 16 + 5
    set_row(4, 37, 1'b1, MODE_LFSR, 3);
    // 4 words left open
    set_row(5, 20, 1'b0, MODE_LFSR, 1);
    // tops up to 16, the flush lands on a full bank
    set_row(6, 12, 1'b1, MODE_LFSR, 1);
    // both banks fill against a stalled output
    set_row(7, 40, 1'b1, MODE_STALL, 3);
    set_row(8, 9, 1'b1, MODE_LFSR, 1);
  endtask

  task automatic reset_outputs_check();
    assert (o_axis_valid == 1'b0) else begin
      $display("ERR t=%0t o_axis_valid expected 0 got %b", $time, o_axis_valid);
      ctrl_errs++;
    end
    assert (o_in_rdy == 1'b0) else begin
      $display("ERR t=%0t o_in_rdy expected 0 got %b", $time, o_in_rdy);
      ctrl_errs++;
    end
  endtask

  // one word, waits for the source window first
  task automatic send_word(input data_t data, input logic last);
    axis_beat_t b;
    int         n;
    n = 0;
    while (!o_in_rdy && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (o_in_rdy) else begin
      $display("timed out at %0t waiting for o_in_rdy", $time);
      timeout_errs++;
    end
    if (o_in_rdy) begin
      b.data = data;
      b.last = last;
      exp_q.push_back(b);
      i_in_stb  = 1'b1;
      i_in_data = data;
      @(posedge clk);
      #1;
      i_in_stb = 1'b0;
    end
  endtask

  task automatic pulse_flush();
    i_flush = 1'b1;
    @(posedge clk);
    #1;
    i_flush = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (exp_q.size() == 0) else begin
      $display("timed out at %0t with %0d beats still expected", $time, exp_q.size());
      timeout_errs++;
    end
  endtask

  // both banks committed, source must stay blocked
  task automatic confirm_input_blocked();
    for (int i = 0; i < STALL_CYCLES; i++) begin
      assert (o_in_rdy == 1'b0) else begin
        $display("ERR t=%0t o_in_rdy expected 0 got %b", $time, o_in_rdy);
        ctrl_errs++;
      end
      @(posedge clk);
      #1;
    end
  endtask

  // ready sampled from mode at the edge, driven 1 ns later
  initial begin : ready_gen
    ready_mode_t m;
    logic        h;
    i_axis_ready = 1'b0;
    lfsr_state   = 32'h36a9;
    forever begin
      @(posedge clk);
      m = cur_mode;
      h = stall_hold;
      #1;
      case (m)
        MODE_LFSR: begin
          i_axis_ready = lfsr_state[0];
          lfsr_state   = lfsr_step(lfsr_state);
        end
        MODE_STALL: i_axis_ready = !h;
        default:    i_axis_ready = 1'b1;
      endcase
    end
  end

  // transfer monitor
  always @(posedge clk) begin : monitor
    axis_beat_t exp_beat;
    if (rst) begin
      hold_pending = 1'b0;
    end else begin
      // stalled beat must still be offered unchanged
      if (hold_pending) begin
        assert (o_axis_valid) else begin
          $display("ERR t=%0t o_axis_valid expected 1 got %b", $time, o_axis_valid);
          hold_errs++;
        end
        assert (o_axis_beat == held_beat) else begin
          $display("ERR t=%0t o_axis_beat expected %h got %h", $time, held_beat,
                   o_axis_beat);
          hold_errs++;
        end
      end
      if (o_axis_valid && i_axis_ready) begin
        assert (exp_q.size() != 0) else begin
          $display("beat %h at %0t arrived with nothing expected", o_axis_beat, $time);
          data_errs++;
        end
        if (exp_q.size() != 0) begin
          exp_beat = exp_q.pop_front();
          assert (o_axis_beat.data == exp_beat.data) else begin
            $display("ERR t=%0t o_axis_beat.data expected %h got %h", $time,
                     exp_beat.data, o_axis_beat.data);
            data_errs++;
          end
          assert (o_axis_beat.last == exp_beat.last) else begin
            $display("ERR t=%0t o_axis_beat.last expected %b got %b", $time,
                     exp_beat.last, o_axis_beat.last);
            last_errs++;
          end
        end
        if (o_axis_beat.last) begin
          pkt_cnt++;
        end
      end
      hold_pending = o_axis_valid && !i_axis_ready;
      held_beat    = o_axis_beat;
    end
  end

  initial begin : driver
    int         pending;
    int         pkts_expected;
    data_t      word;
    axis_beat_t tail;
    rst           = 1'b1;
    i_in_stb      = 1'b0;
    i_in_data     = '0;
    i_flush       = 1'b0;
    pending       = 0;
    pkts_expected = 0;
    word          = 32'h1000;
    load_table();
    bank_words = 1 << ppfifo_stream_top_inst.DEPTH_LOG2;

    repeat (5) begin
      @(posedge clk);
      #1;
      reset_outputs_check();
    end
    rst = 1'b0;
    reset_outputs_check();
    @(posedge clk);
    #1;
    reset_outputs_check();

    for (int r = 0; r < NUM_ROWS && timeout_errs == 0; r++) begin
      // stall row starts from an empty FIFO
      if (rows[r].mode == MODE_STALL) begin
        wait_drain();
        stall_hold = 1'b1;
      end
      cur_mode      = rows[r].mode;
      pkts_expected = pkts_expected + rows[r].pkts;
      for (int w = 0; w < rows[r].words && timeout_errs == 0; w++) begin
        if (rows[r].mode == MODE_STALL && w == 2 * bank_words) begin
          confirm_input_blocked();
          stall_hold = 1'b0;
        end
        pending++;
        send_word(word, pending == bank_words);
        if (pending == bank_words) begin
          pending = 0;
        end
        word++;
      end
      if (rows[r].flush && timeout_errs == 0) begin
        // open words become a packet, tail word gets last
        if (pending != 0) begin
          tail      = exp_q.pop_back();
          tail.last = 1'b1;
          exp_q.push_back(tail);
          pending = 0;
        end
        pulse_flush();
      end
    end

    if (timeout_errs == 0) begin
      wait_drain();
      // idle stretch, stray beats show up in the monitor
      repeat (20) @(posedge clk);
      #1;
      assert (pkt_cnt == pkts_expected) else begin
        $display("ERR t=%0t packet count expected %0d got %0d", $time, pkts_expected,
                 pkt_cnt);
        ctrl_errs++;
      end
    end

    $display("errors: data %0d, last %0d, hold %0d, control %0d, timeout %0d",
             data_errs, last_errs, hold_errs, ctrl_errs, timeout_errs);
    if (data_errs + last_errs + hold_errs + ctrl_errs + timeout_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/adapter_ppfifo_2_axi_stream.sv
// ping-pong FIFO read side to AXI-Stream adapter
//   claims a committed bank and streams it as one packet
//   valid holds until ready, beat data is the fall-through word
//   last on the beat where the counter reaches size minus one
`timescale 1ns/10ps
`default_nettype none

module adapter_ppfifo_2_axi_stream (
  input  wire                     clk,
  input  wire                     rst,

  // FIFO read side
  input  wire                     i_ppfifo_rdy,
  output logic                    o_ppfifo_act,
  input  ppfifo_pkg::size_t       i_ppfifo_size,
  input  ppfifo_pkg::data_t       i_ppfifo_data,
  output logic                    o_ppfifo_stb,

  // AXI-Stream output
  input  wire                     i_axi_ready,
  output logic                    o_axi_valid,
  output ppfifo_pkg::axis_beat_t  o_axi_beat
);

  import ppfifo_pkg::*;

  adapter_state_t r_state;
  // beat index within the packet
  size_t          r_count;

  logic           w_last;
  logic           w_xfer;

  // final word of the bank
  assign w_last  = (r_count == (i_ppfifo_size - size_t'(1)));

  // beat accepted this cycle
  assign w_xfer  = o_axi_valid && i_axi_ready;

  // step the FIFO on every transfer but the last,
  // the bank is freed instead
  assign o_ppfifo_stb = w_xfer && !w_last;

  // word passes straight through, stable while the index holds
  assign o_axi_beat.data = i_ppfifo_data;
  assign o_axi_beat.last = w_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_state      <= IDLE;
      r_count      <= '0;
      o_ppfifo_act <= 1'b0;
      o_axi_valid  <= 1'b0;
    end else begin
      case (r_state)
        IDLE: begin
          // claim the next committed bank
          if (i_ppfifo_rdy) begin
            r_count      <= '0;
            o_ppfifo_act <= 1'b1;
            r_state      <= READY;
          end
        end
        READY: begin
          if (!o_axi_valid) begin
            // first beat, one cycle after the claim
            o_axi_valid <= 1'b1;
          end else if (w_xfer) begin
            if (w_last) begin
              // packet done, drop valid and free the bank
              o_axi_valid  <= 1'b0;
              o_ppfifo_act <= 1'b0;
              r_state      <= RELEASE;
            end else begin
              r_count <= r_count + size_t'(1);
            end
          end
          // no transfer, valid and beat hold
        end
        RELEASE: begin
          // FIFO toggles its read pointer this cycle
          r_state <= IDLE;
        end
        default: begin
          r_state      <= IDLE;
          o_ppfifo_act <= 1'b0;
          o_axi_valid  <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/ppfifo.sv
// two-bank ping-pong FIFO
//   write side claims a bank, fills it and commits it
//   read side claims the committed bank in write order
//   per-bank fill count doubles as the packet size on the read side
//   read data is first word fall-through
`timescale 1ns/10ps
`default_nettype none

module ppfifo #(
  parameter int DEPTH_LOG2 = 4
) (
  input  wire                clk,
  input  wire                rst,

  // write side
  output logic               o_wr_rdy,
  input  wire                i_wr_act,
  input  wire                i_wr_stb,
  input  ppfifo_pkg::data_t  i_wr_data,
  output logic               o_wr_full,

  // read side
  output logic               o_rd_rdy,
  input  wire                i_rd_act,
  input  wire                i_rd_stb,
  output ppfifo_pkg::size_t  o_rd_size,
  output ppfifo_pkg::data_t  o_rd_data
);

  import ppfifo_pkg::*;

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  // bank storage
  data_t                 r_mem [0:1][0:DEPTH-1];

  // per-bank status
  logic [1:0]            r_committed;
  size_t                 r_count [0:1];

  // write side control
  logic                  r_wr_ptr;
  logic                  r_wr_active;

  // read side control
  logic                  r_rd_ptr;
  logic                  r_rd_active;
  logic [DEPTH_LOG2-1:0] r_rd_idx;

  logic [DEPTH_LOG2-1:0] w_wr_idx;
  logic                  w_wr_en;

  // next word goes at the current fill count
  assign w_wr_idx  = r_count[r_wr_ptr][DEPTH_LOG2-1:0];

  // full once the count reaches depth, only meaningful while claimed
  assign o_wr_full = r_wr_active && (r_count[r_wr_ptr] == size_t'(DEPTH));

  // drop strobes past the end of the bank
  assign w_wr_en   = r_wr_active && i_wr_act && i_wr_stb && !o_wr_full;

  // bank in write order must be drained and unclaimed
  assign o_wr_rdy  = !r_wr_active && !r_committed[r_wr_ptr];

  // bank in read order must be committed and unclaimed
  assign o_rd_rdy  = r_committed[r_rd_ptr] && !r_rd_active;

  // fall-through read path
  assign o_rd_size = r_count[r_rd_ptr];
  assign o_rd_data = r_mem[r_rd_ptr][r_rd_idx];

  // word storage
  always_ff @(posedge clk) begin
    if (w_wr_en) begin
      r_mem[r_wr_ptr][w_wr_idx] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_committed <= '0;
      r_count[0]  <= '0;
      r_count[1]  <= '0;
      r_wr_ptr    <= 1'b0;
      r_wr_active <= 1'b0;
      r_rd_ptr    <= 1'b0;
      r_rd_active <= 1'b0;
      r_rd_idx    <= '0;
    end else begin
      // write side
      if (!r_wr_active) begin
        // claim, restart the fill count
        if (i_wr_act && o_wr_rdy) begin
          r_wr_active       <= 1'b1;
          r_count[r_wr_ptr] <= '0;
        end
      end else if (!i_wr_act) begin
        r_wr_active <= 1'b0;
        // an empty bank is handed back without a commit
        if (r_count[r_wr_ptr] != '0) begin
          r_committed[r_wr_ptr] <= 1'b1;
          r_wr_ptr              <= ~r_wr_ptr;
        end
      end else if (w_wr_en) begin
        r_count[r_wr_ptr] <= r_count[r_wr_ptr] + size_t'(1);
      end

      // read side
      // never the same bank as the write side, commit and free cannot collide
      if (!r_rd_active) begin
        if (i_rd_act && o_rd_rdy) begin
          r_rd_active <= 1'b1;
        end
      end else if (!i_rd_act) begin
        // free the bank, move on in write order
        r_rd_active           <= 1'b0;
        r_committed[r_rd_ptr] <= 1'b0;
        r_rd_ptr              <= ~r_rd_ptr;
        // index back to word 0 so the next bank falls through at once
        r_rd_idx              <= '0;
      end else if (i_rd_stb) begin
        r_rd_idx <= r_rd_idx + DEPTH_LOG2'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/ppfifo_pkg.sv
// shared types for the ping-pong FIFO stream path
//   data_t          one stream word
//   size_t          word count of a committed bank
//   axis_beat_t     one output beat, data plus last flag
//   adapter_state_t read adapter state encoding
`default_nettype none

package ppfifo_pkg;

  // stream word width
  typedef logic [31:0] data_t;

  // bank fill count, covers depths up to 2**23 words
  typedef logic [23:0] size_t;

  // one output beat
  // last marks the final word of a bank
  typedef struct packed {
    data_t data;
    logic  last;
  } axis_beat_t;

  // read adapter FSM
  // idle waits for a committed bank
  // ready streams beats
  // release lets the FIFO free the bank
  typedef enum logic [1:0] {
    IDLE,
    READY,
    RELEASE
  } adapter_state_t;

endpackage

`default_nettype wire

// File: verilog/ppfifo_stream_top.sv
// streaming path top level
//   ppfifo_writer                input strobes into the write bank
//   ppfifo                       two-bank ping-pong storage
//   adapter_ppfifo_2_axi_stream  committed banks out as packets
`timescale 1ns/10ps
`default_nettype none

module ppfifo_stream_top #(
  parameter int DEPTH_LOG2 = 4
) (
  input  wire                     clk,
  input  wire                     rst,

  // word input
  input  wire                     i_in_stb,
  input  ppfifo_pkg::data_t       i_in_data,
  input  wire                     i_flush,
  output logic                    o_in_rdy,

  // packet output
  input  wire                     i_axis_ready,
  output logic                    o_axis_valid,
  output ppfifo_pkg::axis_beat_t  o_axis_beat
);

  import ppfifo_pkg::*;

  // writer to FIFO
  logic  wr_rdy;
  logic  wr_act;
  logic  wr_stb;
  data_t wr_data;
  logic  wr_full;

  // FIFO to adapter
  logic  rd_rdy;
  logic  rd_act;
  logic  rd_stb;
  size_t rd_size;
  data_t rd_data;

  ppfifo_writer ppfifo_writer_inst (
    .clk        (clk),
    .rst        (rst),
    .i_in_stb   (i_in_stb),
    .i_in_data  (i_in_data),
    .i_flush    (i_flush),
    .o_in_rdy   (o_in_rdy),
    .i_wr_rdy   (wr_rdy),
    .o_wr_act   (wr_act),
    .o_wr_stb   (wr_stb),
    .o_wr_data  (wr_data),
    .i_wr_full  (wr_full)
  );

  ppfifo #(
    .DEPTH_LOG2 (DEPTH_LOG2)
  ) ppfifo_inst (
    .clk        (clk),
    .rst        (rst),
    .o_wr_rdy   (wr_rdy),
    .i_wr_act   (wr_act),
    .i_wr_stb   (wr_stb),
    .i_wr_data  (wr_data),
    .o_wr_full  (wr_full),
    .o_rd_rdy   (rd_rdy),
    .i_rd_act   (rd_act),
    .i_rd_stb   (rd_stb),
    .o_rd_size  (rd_size),
    .o_rd_data  (rd_data)
  );

  adapter_ppfifo_2_axi_stream adapter_inst (
    .clk            (clk),
    .rst            (rst),
    .i_ppfifo_rdy   (rd_rdy),
    .o_ppfifo_act   (rd_act),
    .i_ppfifo_size  (rd_size),
    .i_ppfifo_data  (rd_data),
    .o_ppfifo_stb   (rd_stb),
    .i_axi_ready    (i_axis_ready),
    .o_axi_valid    (o_axis_valid),
    .o_axi_beat     (o_axis_beat)
  );

endmodule

`default_nettype wire

// File: verilog/ppfifo_writer.sv
// strobe input to ping-pong FIFO write adapter
//   claims the next empty bank
//   forwards input strobes as write strobes
//   commits on full, or on flush once a word is stored
`timescale 1ns/10ps
`default_nettype none

module ppfifo_writer (
  input  wire                clk,
  input  wire                rst,

  // input source
  input  wire                i_in_stb,
  input  ppfifo_pkg::data_t  i_in_data,
  input  wire                i_flush,
  output logic               o_in_rdy,

  // FIFO write side
  input  wire                i_wr_rdy,
  output logic               o_wr_act,
  output logic               o_wr_stb,
  output ppfifo_pkg::data_t  o_wr_data,
  input  wire                i_wr_full
);

  // bank claimed
  logic r_act;
  // source may strobe, one cycle behind the claim
  logic r_rdy;
  // at least one word in the claimed bank
  logic r_has_data;

  logic w_flush_commit;

  // full drops both levels in the cycle right after the filling strobe
  assign o_wr_act  = r_act && !i_wr_full;
  assign o_in_rdy  = r_rdy && !i_wr_full;

  // strobes outside the ready window are ignored
  assign o_wr_stb  = i_in_stb && o_in_rdy;
  assign o_wr_data = i_in_data;

  // flush only commits a bank that holds data,
  // a word arriving with the flush counts
  assign w_flush_commit = i_flush && (r_has_data || o_wr_stb);

  always_ff @(posedge clk) begin
    if (rst) begin
      r_act      <= 1'b0;
      r_rdy      <= 1'b0;
      r_has_data <= 1'b0;
    end else if (!r_act) begin
      // idle, claim as soon as the FIFO offers a bank
      r_has_data <= 1'b0;
      if (i_wr_rdy) begin
        r_act <= 1'b1;
      end
    end else if (!r_rdy) begin
      // claim cycle, FIFO clears the count now
      r_rdy <= 1'b1;
    end else if (i_wr_full || w_flush_commit) begin
      // commit, FIFO sees act low next cycle
      r_act      <= 1'b0;
      r_rdy      <= 1'b0;
      r_has_data <= 1'b0;
    end else if (o_wr_stb) begin
      // a flush with no word stored is simply dropped
      // the next word lands in the same bank
      r_has_data <= 1'b1;
    end
  end

endmodule

`default_nettype wire
